/* rv_stimulus.txt */
# P <byte address> <instruction word>, all hex
# R <destination register> <value written>, all hex, in retire order
P 00000000 00500093  addi x1, x0, 5
P 00000004 ffd00113  addi x2, x0, -3
P 00000008 002081b3  add x3, x1, x2
P 0000000c 40208233  sub x4, x1, x2
P 00000010 001122b3  slt x5, x2, x1
P 00000014 00113333  sltu x6, x2, x1
P 00000018 123453b7  lui x7, 0x12345
P 0000001c 00001417  auipc x8, 0x1
P 00000020 40115493  srai x9, x2, 1
P 00000024 00708013  addi x0, x1, 7
P 00000028 00100533  add x10, x0, x1
P 0000002c 00208463  beq x1, x2, +8 not taken
P 00000030 00209463  bne x1, x2, +8 taken
P 00000034 00100593  addi x11, x0, 1 skipped
P 00000038 0080066f  jal x12, +8
P 0000003c 00200593  addi x11, x0, 2 skipped
P 00000040 00702823  sw x7, 16(x0)
P 00000044 002008a3  sb x2, 17(x0)
P 00000048 00101923  sh x1, 18(x0)
P 0000004c 01002683  lw x13, 16(x0)
P 00000050 01100703  lb x14, 17(x0)
P 00000054 01104783  lbu x15, 17(x0)
P 00000058 01001803  lh x16, 16(x0)
P 0000005c 01205883  lhu x17, 18(x0)
P 00000060 02d60967  jalr x18, 45(x12)
P 00000064 00900993  addi x19, x0, 9 skipped
P 00000068 00114463  blt x2, x1, +8 taken
P 0000006c 00a00993  addi x19, x0, 10 skipped
P 00000070 0000006f  jal x0, 0
P 00000074 00000013  nop
P 00000078 00000013  nop
R 01 00000005
R 02 fffffffd
R 03 00000002
R 04 00000008
R 05 00000001
R 06 00000000
R 07 12345000
R 08 0000101c
R 09 fffffffe
R 0a 00000005
R 0c 0000003c
R 0d 0005fd00
R 0e fffffffd
R 0f 000000fd
R 10 fffffd00
R 11 00000005
R 12 00000064

/* tb.f */
+incdir+.
rv_pkg.sv
rv_memory.sv
rv_regfile.sv
rv_decode.sv
rv_execute.sv
rv_writeback.sv
rv_pipeline.sv
rv_system.sv
tb_rv_system.sv

/* run.sh */
#!/bin/sh
# build and run the RV32I testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tb_rv_system -o tb_sim
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0

/* tb_rv_system.sv */
// ==============================
// testbench for the RV32I system
// program load, retire checks, watchdog
// ==============================

module tb_rv_system import rv_pkg::*; ();

    localparam int CLOCK_HALF   = 20;
    localparam int RESET_CYCLES = 5;
    localparam int DRAIN_CYCLES = 30;

    logic      clock;
    logic      reset;
    logic      load_enable;
    word_t     load_address;
    word_t     load_data;
    logic      run;
    logic      retire_valid;
    reg_addr_t retire_rd;
    word_t     retire_data;

    word_t     program_address [$];
    word_t     program_word [$];
    reg_addr_t expected_rd [$];
    word_t     expected_data [$];

    int   retire_count = 0;
    logic stimulus_ready = 1'b0;

    rv_system uut (
        .clock        (clock),
        .reset        (reset),
        .load_enable  (load_enable),
        .load_address (load_address),
        .load_data    (load_data),
        .run          (run),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    initial begin
        clock = 1'b0;
    end

    always #CLOCK_HALF clock = ~clock;

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
    end

    task automatic stop_with_failure();
        $display("Test failed");
        $fatal(1, "simulation stopped after a failure");
    endtask

    task automatic compare_rd(input reg_addr_t actual, input reg_addr_t expected,
                              input int index);
        if (actual !== expected) begin
            $display("FAILED at %0t: retire %0d wrote x%0d, expected x%0d",
                     $time, index, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic compare_data(input word_t actual, input word_t expected,
                                input reg_addr_t rd, input int index);
        if (actual !== expected) begin
            $display("FAILED at %0t: retire %0d to x%0d gave %h, expected %h",
                     $time, index, rd, actual, expected);
            stop_with_failure();
        end
    endtask

    // P lines hold program words and R lines the expected retires
    task automatic read_stimulus();
        int    fd;
        int    fields;
        string line;
        byte   kind;
        word_t first;
        word_t second;
        fd = $fopen("rv_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file rv_stimulus.txt");
            stop_with_failure();
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 2) begin
                    kind = line.getc(0);
                    if (kind == "P" || kind == "R") begin
                        fields = $sscanf(line.substr(1, line.len() - 1), "%h %h",
                                         first, second);
                        if (fields != 2) begin
                            $display("malformed stimulus line: %s", line);
                            stop_with_failure();
                        end else if (kind == "P") begin
                            program_address.push_back(first);
                            program_word.push_back(second);
                        end else begin
                            expected_rd.push_back(reg_addr_t'(first));
                            expected_data.push_back(second);
                        end
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        int pause;
        void'($urandom(32'h57b6_59fd));
        load_enable  = 1'b0;
        load_address = '0;
        load_data    = '0;
        run          = 1'b0;
        read_stimulus();
        stimulus_ready = 1'b1;

        // program load overlaps the reset window
        foreach (program_word[i]) begin
            @(posedge clock);
            load_enable  <= 1'b1;
            load_address <= program_address[i];
            load_data    <= program_word[i];
        end
        @(posedge clock);
        load_enable <= 1'b0;
        wait (!reset);
        @(posedge clock);
        run <= 1'b1;

        // random pauses on run while the program executes
        while (retire_count < expected_rd.size()) begin
            @(posedge clock);
            if (($urandom % 8) == 0) begin
                pause = 1 + int'($urandom % 6);
                run <= 1'b0;
                repeat (pause) @(posedge clock);
                run <= 1'b1;
            end
        end

        // nothing more may retire while the program spins on its last jump
        repeat (DRAIN_CYCLES) @(posedge clock);
        $display("Test completed successfully");
        $finish;
    end

    // retire outputs sampled on the falling edge
    always @(negedge clock) begin
        if (!reset && retire_valid) begin
            if (retire_count >= expected_rd.size()) begin
                $display("unexpected retire of x%0d at %0t after the last expected one",
                         retire_rd, $time);
                stop_with_failure();
            end else begin
                compare_rd(retire_rd, expected_rd[retire_count], retire_count);
                compare_data(retire_data, expected_data[retire_count], retire_rd,
                             retire_count);
                retire_count++;
            end
        end
    end

    initial begin
        int limit;
        wait (stimulus_ready);
        limit = 200 * expected_rd.size() + 1000;
        repeat (limit) @(posedge clock);
        $display("timeout: the retire sequence did not complete within %0d cycles", limit);
        stop_with_failure();
    end

endmodule

/* rv_system.sv */
// ==============================
// top level: pipeline with
// instruction and data memories
// ==============================

`include "rv_settings.svh"

module rv_system import rv_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      load_enable,
    input  word_t     load_address,
    input  word_t     load_data,
    input  logic      run,
    output logic      retire_valid,
    output reg_addr_t retire_rd,
    output word_t     retire_data
);
    word_t imem_address, imem_data, imem_port_address;
    word_t dmem_address, dmem_write_data, dmem_read_data;
    logic [3:0] dmem_byte_enable;
    logic dmem_write;

    rv_pipeline pipeline (
        .clock            (clock),
        .reset            (reset),
        .run              (run),
        .imem_address     (imem_address),
        .imem_data        (imem_data),
        .dmem_address     (dmem_address),
        .dmem_write_data  (dmem_write_data),
        .dmem_byte_enable (dmem_byte_enable),
        .dmem_write       (dmem_write),
        .dmem_read_data   (dmem_read_data),
        .retire_valid     (retire_valid),
        .retire_rd        (retire_rd),
        .retire_data      (retire_data)
    );

    // loads share the single address port, run is low while they happen
    assign imem_port_address = load_enable ? load_address : imem_address;

    rv_memory #(
        .DEPTH(`RV_IMEM_WORDS)
    ) imem (
        .clock       (clock),
        .write       (load_enable),
        .byte_enable (4'b1111),
        .address     (imem_port_address),
        .write_data  (load_data),
        .read_data   (imem_data)
    );

    rv_memory #(
        .DEPTH(`RV_DMEM_WORDS)
    ) dmem (
        .clock       (clock),
        .write       (dmem_write),
        .byte_enable (dmem_byte_enable),
        .address     (dmem_address),
        .write_data  (dmem_write_data),
        .read_data   (dmem_read_data)
    );

endmodule

/* rv_pipeline.sv */
// ==============================
// five-stage pipeline: PC, stage
// registers, stall/flush, store lanes
// ==============================

`include "rv_settings.svh"

module rv_pipeline import rv_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       run,
    output word_t      imem_address,
    input  word_t      imem_data,
    output word_t      dmem_address,
    output word_t      dmem_write_data,
    output logic [3:0] dmem_byte_enable,
    output logic       dmem_write,
    input  word_t      dmem_read_data,
    output logic       retire_valid,
    output reg_addr_t  retire_rd,
    output word_t      retire_data
);
    word_t pc;

    // decode stage
    word_t id_inst, id_pc, id_immediate, id_rs1_data, id_rs2_data;
    reg_addr_t id_rd, id_rs1, id_rs2;
    logic id_uses_rs1, id_uses_rs2, id_operand_a_pc, id_operand_b_imm;
    logic id_reg_write, id_mem_read, id_mem_write;
    alu_op_t id_alu_op;
    branch_t id_branch;
    wb_sel_t id_wb_sel;
    mem_format_t id_mem_format;

    // execute stage
    word_t ex_pc, ex_rs1_data, ex_rs2_data, ex_immediate;
    word_t ex_alu_result, ex_branch_target;
    reg_addr_t ex_rd;
    logic ex_operand_a_pc, ex_operand_b_imm, ex_branch_taken;
    logic ex_reg_write, ex_mem_read, ex_mem_write;
    alu_op_t ex_alu_op;
    branch_t ex_branch;
    wb_sel_t ex_wb_sel;
    mem_format_t ex_mem_format;

    // memory stage
    word_t ma_alu_result, ma_rs2_data, ma_immediate, ma_pc_plus_4;
    reg_addr_t ma_rd;
    logic ma_reg_write, ma_mem_read, ma_mem_write;
    wb_sel_t ma_wb_sel;
    mem_format_t ma_mem_format;

    // writeback stage
    word_t wb_alu_result, wb_load_data, wb_pc_plus_4, wb_immediate, wb_rd_data;
    reg_addr_t wb_rd;
    logic wb_reg_write;
    wb_sel_t wb_wb_sel;
    mem_format_t wb_mem_format;

    logic hazard_rs1, hazard_rs2, stall;

    // stall until the producer has left WB
    assign hazard_rs1 = id_uses_rs1 && id_rs1 != 5'd0 &&
        ((ex_reg_write && ex_rd == id_rs1) || (ma_reg_write && ma_rd == id_rs1) ||
         (wb_reg_write && wb_rd == id_rs1));
    assign hazard_rs2 = id_uses_rs2 && id_rs2 != 5'd0 &&
        ((ex_reg_write && ex_rd == id_rs2) || (ma_reg_write && ma_rd == id_rs2) ||
         (wb_reg_write && wb_rd == id_rs2));
    assign stall = hazard_rs1 || hazard_rs2;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc <= `RV_RESET_PC;
        end else if (ex_branch_taken) begin
            pc <= ex_branch_target;
        end else if (run && !stall) begin
            pc <= pc + 32'd4;
        end
    end

    assign imem_address = pc;

    // taken branch or idle run puts a NOP into IF/ID
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            id_inst <= NOP_INST;
        end else if (ex_branch_taken || (!stall && !run)) begin
            id_inst <= NOP_INST;
        end else if (!stall) begin
            id_inst <= imem_data;
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            id_pc <= pc;
        end
    end

    rv_decode decode (
        .inst          (id_inst),
        .rd            (id_rd),
        .rs1           (id_rs1),
        .rs2           (id_rs2),
        .immediate     (id_immediate),
        .uses_rs1      (id_uses_rs1),
        .uses_rs2      (id_uses_rs2),
        .alu_op        (id_alu_op),
        .operand_a_pc  (id_operand_a_pc),
        .operand_b_imm (id_operand_b_imm),
        .branch        (id_branch),
        .reg_write     (id_reg_write),
        .wb_sel        (id_wb_sel),
        .mem_read      (id_mem_read),
        .mem_write     (id_mem_write),
        .mem_format    (id_mem_format)
    );

    rv_regfile regfile (
        .clock        (clock),
        .write_enable (wb_reg_write),
        .rd_address   (wb_rd),
        .rs1_address  (id_rs1),
        .rs2_address  (id_rs2),
        .rd_data      (wb_rd_data),
        .rs1_data     (id_rs1_data),
        .rs2_data     (id_rs2_data)
    );

    // bubble into ID/EX on stall or flush
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ex_reg_write <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_branch    <= BR_NONE;
        end else if (stall || ex_branch_taken) begin
            ex_reg_write <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_branch    <= BR_NONE;
        end else begin
            ex_reg_write <= id_reg_write;
            ex_mem_read  <= id_mem_read;
            ex_mem_write <= id_mem_write;
            ex_branch    <= id_branch;
        end
    end

    always_ff @(posedge clock) begin
        ex_pc            <= id_pc;
        ex_rs1_data      <= id_rs1_data;
        ex_rs2_data      <= id_rs2_data;
        ex_immediate     <= id_immediate;
        ex_rd            <= id_rd;
        ex_alu_op        <= id_alu_op;
        ex_operand_a_pc  <= id_operand_a_pc;
        ex_operand_b_imm <= id_operand_b_imm;
        ex_wb_sel        <= id_wb_sel;
        ex_mem_format    <= id_mem_format;
    end

    rv_execute execute (
        .alu_op        (ex_alu_op),
        .operand_a_pc  (ex_operand_a_pc),
        .operand_b_imm (ex_operand_b_imm),
        .branch        (ex_branch),
        .pc            (ex_pc),
        .rs1_data      (ex_rs1_data),
        .rs2_data      (ex_rs2_data),
        .immediate     (ex_immediate),
        .alu_result    (ex_alu_result),
        .branch_taken  (ex_branch_taken),
        .branch_target (ex_branch_target)
    );

    // EX/MEM
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ma_reg_write <= 1'b0;
            ma_mem_read  <= 1'b0;
            ma_mem_write <= 1'b0;
        end else begin
            ma_reg_write <= ex_reg_write;
            ma_mem_read  <= ex_mem_read;
            ma_mem_write <= ex_mem_write;
        end
    end

    always_ff @(posedge clock) begin
        ma_rd         <= ex_rd;
        ma_alu_result <= ex_alu_result;
        ma_rs2_data   <= ex_rs2_data;
        ma_immediate  <= ex_immediate;
        ma_pc_plus_4  <= ex_pc + 32'd4;
        ma_wb_sel     <= ex_wb_sel;
        ma_mem_format <= ex_mem_format;
    end

    // store data replicated across lanes and picked by the byte enables
    always_comb begin
        case (ma_mem_format)
            MEM_B: begin
                dmem_write_data  = {4{ma_rs2_data[7:0]}};
                dmem_byte_enable = 4'b0001 << ma_alu_result[1:0];
            end
            MEM_H: begin
                dmem_write_data  = {2{ma_rs2_data[15:0]}};
                dmem_byte_enable = 4'b0011 << {ma_alu_result[1], 1'b0};
            end
            MEM_W: begin
                dmem_write_data  = ma_rs2_data;
                dmem_byte_enable = 4'b1111;
            end
            default: begin
                dmem_write_data  = ma_rs2_data;
                dmem_byte_enable = 4'b0000;
            end
        endcase
    end

    assign dmem_address = ma_alu_result;
    assign dmem_write   = ma_mem_write;

    // MEM/WB
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wb_reg_write <= 1'b0;
        end else begin
            wb_reg_write <= ma_reg_write;
        end
    end

    always_ff @(posedge clock) begin
        wb_rd         <= ma_rd;
        wb_alu_result <= ma_alu_result;
        wb_pc_plus_4  <= ma_pc_plus_4;
        wb_immediate  <= ma_immediate;
        wb_wb_sel     <= ma_wb_sel;
        wb_mem_format <= ma_mem_format;
        if (ma_mem_read) begin
            wb_load_data <= dmem_read_data;
        end
    end

    rv_writeback writeback (
        .wb_sel      (wb_wb_sel),
        .mem_format  (wb_mem_format),
        .byte_offset (wb_alu_result[1:0]),
        .alu_result  (wb_alu_result),
        .load_data   (wb_load_data),
        .pc_plus_4   (wb_pc_plus_4),
        .immediate   (wb_immediate),
        .rd_data     (wb_rd_data)
    );

    assign retire_valid = wb_reg_write && wb_rd != 5'd0;
    assign retire_rd    = wb_rd;
    assign retire_data  = wb_rd_data;

endmodule

/* rv_writeback.sv */
// ==============================
// load extraction and writeback
// source select
// ==============================

module rv_writeback import rv_pkg::*; (
    input  wb_sel_t     wb_sel,
    input  mem_format_t mem_format,
    input  logic [1:0]  byte_offset,
    input  word_t       alu_result,
    input  word_t       load_data,
    input  word_t       pc_plus_4,
    input  word_t       immediate,
    output word_t       rd_data
);
    word_t shifted;
    word_t load_value;

    // addressed byte or half moved down to bit 0
    assign shifted = load_data >> {byte_offset, 3'b000};

    always_comb begin
        case (mem_format)
            MEM_B:   load_value = {{24{shifted[7]}}, shifted[7:0]};
            MEM_H:   load_value = {{16{shifted[15]}}, shifted[15:0]};
            MEM_BU:  load_value = {24'b0, shifted[7:0]};
            MEM_HU:  load_value = {16'b0, shifted[15:0]};
            default: load_value = load_data;
        endcase
    end

    always_comb begin
        case (wb_sel)
            WB_ALU:       rd_data = alu_result;
            WB_LOAD:      rd_data = load_value;
            WB_PC_PLUS_4: rd_data = pc_plus_4;
            default:      rd_data = immediate;
        endcase
    end

endmodule

/* rv_execute.sv */
// ==============================
// execute stage: ALU, branch
// decision and target
// ==============================

module rv_execute import rv_pkg::*; (
    input  alu_op_t alu_op,
    input  logic    operand_a_pc,
    input  logic    operand_b_imm,
    input  branch_t branch,
    input  word_t   pc,
    input  word_t   rs1_data,
    input  word_t   rs2_data,
    input  word_t   immediate,
    output word_t   alu_result,
    output logic    branch_taken,
    output word_t   branch_target
);
    word_t operand_a, operand_b;
    word_t jalr_sum;

    assign operand_a = operand_a_pc ? pc : rs1_data;
    assign operand_b = operand_b_imm ? immediate : rs2_data;

    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_result = operand_a + operand_b;
            ALU_SUB:  alu_result = operand_a - operand_b;
            ALU_SLL:  alu_result = operand_a << operand_b[4:0];
            ALU_SLT:  alu_result = {31'b0, $signed(operand_a) < $signed(operand_b)};
            ALU_SLTU: alu_result = {31'b0, operand_a < operand_b};
            ALU_XOR:  alu_result = operand_a ^ operand_b;
            ALU_SRL:  alu_result = operand_a >> operand_b[4:0];
            ALU_SRA:  alu_result = $signed(operand_a) >>> operand_b[4:0];
            ALU_OR:   alu_result = operand_a | operand_b;
            default:  alu_result = operand_a & operand_b;
        endcase
    end

    always_comb begin
        case (branch)
            BR_BEQ:  branch_taken = rs1_data == rs2_data;
            BR_BNE:  branch_taken = rs1_data != rs2_data;
            BR_BLT:  branch_taken = $signed(rs1_data) < $signed(rs2_data);
            BR_BGE:  branch_taken = $signed(rs1_data) >= $signed(rs2_data);
            BR_BLTU: branch_taken = rs1_data < rs2_data;
            BR_BGEU: branch_taken = rs1_data >= rs2_data;
            BR_JAL:  branch_taken = 1'b1;
            BR_JALR: branch_taken = 1'b1;
            default: branch_taken = 1'b0;
        endcase
    end

    // jalr clears bit 0 of the sum
    assign jalr_sum      = rs1_data + immediate;
    assign branch_target = (branch == BR_JALR) ? {jalr_sum[31:1], 1'b0} : pc + immediate;

endmodule

/* rv_decode.sv */
// ==============================
// instruction decode: fields,
// immediates and control
// ==============================

module rv_decode import rv_pkg::*; (
    input  word_t       inst,
    output reg_addr_t   rd,
    output reg_addr_t   rs1,
    output reg_addr_t   rs2,
    output word_t       immediate,
    output logic        uses_rs1,
    output logic        uses_rs2,
    output alu_op_t     alu_op,
    output logic        operand_a_pc,
    output logic        operand_b_imm,
    output branch_t     branch,
    output logic        reg_write,
    output wb_sel_t     wb_sel,
    output logic        mem_read,
    output logic        mem_write,
    output mem_format_t mem_format
);
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    word_t imm_i, imm_s, imm_b, imm_u, imm_j;
    alu_op_t arith_op;

    assign opcode     = inst[6:0];
    assign funct3     = inst[14:12];
    assign rd         = inst[11:7];
    assign rs1        = inst[19:15];
    assign rs2        = inst[24:20];
    assign mem_format = funct3;

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // funct7 bit 5 picks SUB only for register-register ops
    always_comb begin
        case (funct3)
            3'b000: arith_op = (opcode == OP_REG && inst[30]) ? ALU_SUB : ALU_ADD;
            3'b001: arith_op = ALU_SLL;
            3'b010: arith_op = ALU_SLT;
            3'b011: arith_op = ALU_SLTU;
            3'b100: arith_op = ALU_XOR;
            3'b101: arith_op = inst[30] ? ALU_SRA : ALU_SRL;
            3'b110: arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        immediate     = imm_i;
        uses_rs1      = 1'b0;
        uses_rs2      = 1'b0;
        alu_op        = ALU_ADD;
        operand_a_pc  = 1'b0;
        operand_b_imm = 1'b0;
        branch        = BR_NONE;
        reg_write     = 1'b0;
        wb_sel        = WB_ALU;
        mem_read      = 1'b0;
        mem_write     = 1'b0;
        case (opcode)
            OP_LUI: begin
                immediate = imm_u;
                reg_write = 1'b1;
                wb_sel    = WB_IMMEDIATE;
            end
            OP_AUIPC: begin
                immediate     = imm_u;
                operand_a_pc  = 1'b1;
                operand_b_imm = 1'b1;
                reg_write     = 1'b1;
            end
            OP_JAL: begin
                immediate = imm_j;
                branch    = BR_JAL;
                reg_write = 1'b1;
                wb_sel    = WB_PC_PLUS_4;
            end
            OP_JALR: begin
                uses_rs1  = 1'b1;
                branch    = BR_JALR;
                reg_write = 1'b1;
                wb_sel    = WB_PC_PLUS_4;
            end
            OP_BRANCH: begin
                immediate = imm_b;
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                case (funct3)
                    3'b000: branch = BR_BEQ;
                    3'b001: branch = BR_BNE;
                    3'b100: branch = BR_BLT;
                    3'b101: branch = BR_BGE;
                    3'b110: branch = BR_BLTU;
                    3'b111: branch = BR_BGEU;
                    default: branch = BR_NONE;
                endcase
            end
            OP_LOAD: begin
                uses_rs1      = 1'b1;
                operand_b_imm = 1'b1;
                reg_write     = 1'b1;
                wb_sel        = WB_LOAD;
                mem_read      = 1'b1;
            end
            OP_STORE: begin
                immediate     = imm_s;
                uses_rs1      = 1'b1;
                uses_rs2      = 1'b1;
                operand_b_imm = 1'b1;
                mem_write     = 1'b1;
            end
            OP_IMM: begin
                uses_rs1      = 1'b1;
                operand_b_imm = 1'b1;
                alu_op        = arith_op;
                reg_write     = 1'b1;
            end
            OP_REG: begin
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                alu_op    = arith_op;
                reg_write = 1'b1;
            end
            // anything else passes as a NOP
            default: begin
            end
        endcase
    end

endmodule

/* rv_regfile.sv */
// ==============================
// 32-entry register file, x0 reads zero
// ==============================

module rv_regfile import rv_pkg::*; (
    input  logic      clock,
    input  logic      write_enable,
    input  reg_addr_t rd_address,
    input  reg_addr_t rs1_address,
    input  reg_addr_t rs2_address,
    input  word_t     rd_data,
    output word_t     rs1_data,
    output word_t     rs2_data
);
    word_t registers [1:31];

    always_ff @(posedge clock) begin
        if (write_enable && rd_address != 5'd0) begin
            registers[rd_address] <= rd_data;
        end
    end

    // no write-to-read bypass, decode stalls on a pending WB write instead
    assign rs1_data = (rs1_address == 5'd0) ? '0 : registers[rs1_address];
    assign rs2_data = (rs2_address == 5'd0) ? '0 : registers[rs2_address];

endmodule

/* rv_memory.sv */
// ==============================
// word memory, byte-enable write,
// combinational read
// ==============================

module rv_memory import rv_pkg::*; #(
    parameter int DEPTH = 64
) (
    input  logic       clock,
    input  logic       write,
    input  logic [3:0] byte_enable,
    input  word_t      address,
    input  word_t      write_data,
    output word_t      read_data
);
    localparam int INDEX_BITS = $clog2(DEPTH);

    word_t words [DEPTH];
    logic [INDEX_BITS-1:0] index;

    // byte offset dropped, upper bits wrap
    assign index = address[INDEX_BITS+1:2];

    always_ff @(posedge clock) begin
        if (write) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (byte_enable[lane]) begin
                    words[index][8*lane +: 8] <= write_data[8*lane +: 8];
                end
            end
        end
    end

    assign read_data = words[index];

endmodule

/* rv_pkg.sv */
// ==============================
// shared types of the RV32I core
// word, register index, control enums
// ==============================

package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_addr_t;

    // funct3 of a load or store, bit 2 is the unsigned flag
    typedef logic [2:0] mem_format_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_LOAD,
        WB_PC_PLUS_4,
        WB_IMMEDIATE
    } wb_sel_t;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU,
        BR_JAL,
        BR_JALR
    } branch_t;

    localparam mem_format_t MEM_B  = 3'b000;
    localparam mem_format_t MEM_H  = 3'b001;
    localparam mem_format_t MEM_W  = 3'b010;
    localparam mem_format_t MEM_BU = 3'b100;
    localparam mem_format_t MEM_HU = 3'b101;

    // addi x0, x0, 0
    localparam word_t NOP_INST = 32'h0000_0013;

endpackage

/* rv_settings.svh */
// ==============================
// reset PC and memory depths
// for the RV32I core
// ==============================

`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// memory depths in 32-bit words
`define RV_IMEM_WORDS 256
`define RV_DMEM_WORDS 256

`endif
